// ==== src/pwmPkg.sv ====
`default_nettype none

package pwmPkg;

	localparam int widthW = 12;   // Pulse width and cycle count
	localparam int dataW  = 16;   // Register word and sample
	localparam int tmW    = 4;

	typedef logic [widthW-1:0] width_t;
	typedef logic [dataW-1:0]  data_t;

	// Word offsets, byte offset over two
	typedef enum logic [4:0] {
		RegIrqClr = 5'h0E,
		RegCtrl   = 5'h18,
		RegCycle  = 5'h19,
		RegLeft   = 5'h1A,
		RegRight  = 5'h1B,
		RegMono   = 5'h1C
	} regOfs_t;

	localparam data_t ctrlMask = 16'h0F93;

	// Control register fields
	localparam int ctrlLeftEn  = 0;
	localparam int ctrlRightEn = 1;
	localparam int ctrlMono    = 4;
	localparam int ctrlRtp     = 7;    // DMA request enable
	localparam int ctrlTmLsb   = 8;    // Tm in periods, 0 counts as 1

endpackage

`default_nettype wire

// ==== src/pwFifo.sv ====
`default_nettype none

module pwFifo import pwmPkg::*; #(
	parameter int Depth = 3
) (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   Push,
	input  width_t PushPw,
	input  logic   Pop,
	output width_t HeadPw,
	output logic   Full,
	output logic   Empty
);

	localparam int ptrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int cntW = $clog2(Depth + 1);

	width_t          mem [Depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic            doPush;
	logic            doPop;

	// Ring wrap at Depth, need not be a power of two
	function automatic logic [ptrW-1:0] nextPtr(logic [ptrW-1:0] p);
		return (p == ptrW'(Depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign Full   = count == cntW'(Depth);
	assign Empty  = count == '0;
	assign HeadPw = mem[rdPtr];
	assign doPush = Push && !Full;   // Lost when full
	assign doPop  = Pop && !Empty;

	always_ff @(posedge CLK) begin
		if (doPush)
			mem[wrPtr] <= PushPw;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	countInRange: assert property (@(posedge CLK) disable iff (!RST_N)
		count <= cntW'(Depth));

endmodule

`default_nettype wire

// ==== src/pwmRegs.sv ====
`default_nettype none

module pwmRegs import pwmPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       Tick,
	input  logic       Period,
	input  logic       RegWr,
	input  logic       RegRd,
	input  regOfs_t    RegAddr,
	input  logic [1:0] RegBe,
	input  data_t      RegWdata,
	input  logic       LeftFull,
	input  logic       LeftEmpty,
	input  logic       RightFull,
	input  logic       RightEmpty,
	output data_t      RegRdata,
	output data_t      Ctrl,
	output width_t     Cycle,
	output logic       LeftPush,
	output logic       RightPush,
	output width_t     LeftPw,
	output width_t     RightPw,
	output logic       IrqClr
);

	logic leftPend;
	logic rightPend;
	logic pushSlot;

	// Byte lane merge, be[0] low byte, be[1] high byte
	function automatic data_t mergeBytes(data_t cur, data_t wd, logic [1:0] be);
		data_t res;
		res = cur;
		if (be[0])
			res[7:0] = wd[7:0];
		if (be[1])
			res[15:8] = wd[15:8];
		return res;
	endfunction

	// Pops own the Period tick, pushes wait for the next free one
	assign pushSlot  = Tick && !Period;
	assign LeftPush  = pushSlot && leftPend;
	assign RightPush = pushSlot && rightPend;
	assign IrqClr    = RegWr && RegAddr == RegIrqClr;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			Ctrl      <= '0;
			Cycle     <= '0;
			LeftPw    <= '0;
			RightPw   <= '0;
			leftPend  <= 1'b0;
			rightPend <= 1'b0;
		end else begin
			if (LeftPush)
				leftPend <= 1'b0;
			if (RightPush)
				rightPend <= 1'b0;

			if (RegWr) begin
				case (RegAddr)
					RegCtrl: Ctrl <= mergeBytes(Ctrl, RegWdata, RegBe) & ctrlMask;
					RegCycle: Cycle <= width_t'(mergeBytes(data_t'(Cycle), RegWdata, RegBe));
					RegLeft: begin
						LeftPw   <= width_t'(mergeBytes(data_t'(LeftPw), RegWdata, RegBe));
						leftPend <= 1'b1;      // New write wins over release
					end
					RegRight: begin
						RightPw   <= width_t'(mergeBytes(data_t'(RightPw), RegWdata, RegBe));
						rightPend <= 1'b1;
					end
					RegMono: begin
						LeftPw    <= width_t'(mergeBytes(data_t'(LeftPw), RegWdata, RegBe));
						RightPw   <= width_t'(mergeBytes(data_t'(RightPw), RegWdata, RegBe));
						leftPend  <= 1'b1;
						rightPend <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Width reads carry FIFO status in the top bits
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			RegRdata <= '0;
		end else if (RegRd) begin
			case (RegAddr)
				RegCtrl:  RegRdata <= Ctrl;
				RegCycle: RegRdata <= data_t'(Cycle);
				RegLeft:  RegRdata <= {LeftFull, LeftEmpty, 2'b00, LeftPw};
				RegRight: RegRdata <= {RightFull, RightEmpty, 2'b00, RightPw};
				RegMono:  RegRdata <= {RightFull, RightEmpty, 2'b00, RightPw};
				default:  RegRdata <= '0;
			endcase
		end
	end

	// Push never meets a pop, so the FIFO holds data afterwards
	leftPushLands: assert property (@(posedge CLK) disable iff (!RST_N)
		LeftPush |=> !LeftEmpty);

	rightPushLands: assert property (@(posedge CLK) disable iff (!RST_N)
		RightPush |=> !RightEmpty);

	// Push into a full FIFO is dropped and must not wrap
	leftFullDrop: assert property (@(posedge CLK) disable iff (!RST_N)
		(LeftPush && LeftFull) |=> LeftFull);

endmodule

`default_nettype wire

// ==== src/pwmTimer.sv ====
`default_nettype none

module pwmTimer import pwmPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  logic   Tick,
	input  data_t  Ctrl,
	input  width_t Cycle,
	input  logic   LeftEmpty,
	input  logic   RightEmpty,
	input  logic   IrqClr,
	output logic   Period,
	output logic   LeftValid,
	output logic   RightValid,
	output logic   PwmIrq,
	output logic   PwmDreq
);

	width_t         cycCnt;
	width_t         cycNext;
	logic [tmW-1:0] tmCnt;
	logic [tmW-1:0] tmNext;
	logic [tmW-1:0] tmLimit;
	logic           running;
	logic           expire;
	logic           dreqPend;

	assign running = (Ctrl[ctrlLeftEn] || Ctrl[ctrlRightEn]) && Cycle != '0;
	assign cycNext = cycCnt + 1'b1;
	assign Period  = Tick && running && cycNext >= Cycle;   // >= also ends a shrunk cycle

	assign tmLimit = (Ctrl[ctrlTmLsb +: tmW] == '0) ? tmW'(1) : Ctrl[ctrlTmLsb +: tmW];
	assign tmNext  = tmCnt + 1'b1;
	assign expire  = Period && tmNext >= tmLimit;

	// Qualified on the Period edge while the head is still in place
	assign RightValid = Period && !RightEmpty;
	assign LeftValid  = Period && (Ctrl[ctrlMono] ? !RightEmpty : !LeftEmpty);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt <= '0;
			tmCnt  <= '0;
		end else if (!running) begin
			cycCnt <= '0;
			tmCnt  <= '0;
		end else if (Period) begin
			cycCnt <= '0;
			tmCnt  <= expire ? '0 : tmNext;
		end else if (Tick) begin
			cycCnt <= cycNext;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			PwmIrq   <= 1'b0;
			PwmDreq  <= 1'b0;
			dreqPend <= 1'b0;
		end else begin
			if (expire)
				PwmIrq <= 1'b1;
			else if (IrqClr)
				PwmIrq <= 1'b0;

			PwmDreq <= Tick && dreqPend;   // One clock wide
			if (expire && Ctrl[ctrlRtp])
				dreqPend <= 1'b1;
			else if (Tick)
				dreqPend <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/pwmScaler.sv ====
`default_nettype none

module pwmScaler import pwmPkg::*; (
	input  logic   CLK,
	input  logic   RST_N,
	input  data_t  Ctrl,
	input  width_t Cycle,
	input  logic   LeftValid,
	input  logic   RightValid,
	input  width_t LeftPw,
	input  width_t RightPw,
	output data_t  PwmL,
	output data_t  PwmR
);

	width_t leftSel;

	// Width to signed sample, centered on half the cycle
	function automatic data_t toSample(width_t pw, width_t cyc);
		width_t half;
		width_t tmp;
		data_t  res;
		half = cyc >> 1;
		if (pw == '0)
			tmp = '0;
		else if (pw > cyc)
			tmp = half;       // Clipped
		else
			tmp = pw - half;
		if (!cyc[widthW-1])
			res = {tmp[11], tmp[9:0], 5'b00000};
		else
			res = {tmp, 4'b0000};
		return res;
	endfunction

	assign leftSel = Ctrl[ctrlMono] ? RightPw : LeftPw;   // Mono plays right on both

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			PwmL <= '0;
			PwmR <= '0;
		end else begin
			if (LeftValid)
				PwmL <= toSample(leftSel, Cycle);
			if (RightValid)
				PwmR <= toSample(RightPw, Cycle);
		end
	end

endmodule

`default_nettype wire

// ==== src/pwmUnit.sv ====
`default_nettype none

module pwmUnit import pwmPkg::*; #(
	parameter int FifoDepth = 3
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       Tick,
	input  logic       RegWr,
	input  regOfs_t    RegAddr,
	input  logic [1:0] RegBe,
	input  data_t      RegWdata,
	input  logic       RegRd,
	output data_t      RegRdata,
	output data_t      PwmL,
	output data_t      PwmR,
	output logic       PwmIrq,
	output logic       PwmDreq
);

	data_t  ctrl;
	width_t cycle;
	logic   leftPush;
	logic   rightPush;
	width_t leftPw;
	width_t rightPw;
	logic   irqClr;
	logic   leftFull;
	logic   leftEmpty;
	logic   rightFull;
	logic   rightEmpty;
	width_t leftHead;
	width_t rightHead;
	logic   period;
	logic   leftValid;
	logic   rightValid;

	pwmRegs uRegs (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.Tick       (Tick),
		.Period     (period),
		.RegWr      (RegWr),
		.RegRd      (RegRd),
		.RegAddr    (RegAddr),
		.RegBe      (RegBe),
		.RegWdata   (RegWdata),
		.LeftFull   (leftFull),
		.LeftEmpty  (leftEmpty),
		.RightFull  (rightFull),
		.RightEmpty (rightEmpty),
		.RegRdata   (RegRdata),
		.Ctrl       (ctrl),
		.Cycle      (cycle),
		.LeftPush   (leftPush),
		.RightPush  (rightPush),
		.LeftPw     (leftPw),
		.RightPw    (rightPw),
		.IrqClr     (irqClr)
	);

	pwFifo #(.Depth(FifoDepth)) uLeftFifo (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.Push   (leftPush),
		.PushPw (leftPw),
		.Pop    (period),
		.HeadPw (leftHead),
		.Full   (leftFull),
		.Empty  (leftEmpty)
	);

	pwFifo #(.Depth(FifoDepth)) uRightFifo (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.Push   (rightPush),
		.PushPw (rightPw),
		.Pop    (period),
		.HeadPw (rightHead),
		.Full   (rightFull),
		.Empty  (rightEmpty)
	);

	pwmTimer uTimer (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.Tick       (Tick),
		.Ctrl       (ctrl),
		.Cycle      (cycle),
		.LeftEmpty  (leftEmpty),
		.RightEmpty (rightEmpty),
		.IrqClr     (irqClr),
		.Period     (period),
		.LeftValid  (leftValid),
		.RightValid (rightValid),
		.PwmIrq     (PwmIrq),
		.PwmDreq    (PwmDreq)
	);

	pwmScaler uScaler (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.Ctrl       (ctrl),
		.Cycle      (cycle),
		.LeftValid  (leftValid),
		.RightValid (rightValid),
		.LeftPw     (leftHead),
		.RightPw    (rightHead),
		.PwmL       (PwmL),
		.PwmR       (PwmR)
	);

endmodule

`default_nettype wire

// ==== tb/tbPwmUnit.sv ====
`default_nettype none

module tbPwmUnit import pwmPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int nRows = 5;

	logic       CLK;
	logic       RST_N;
	logic       Tick;
	logic       RegWr;
	logic       RegRd;
	regOfs_t    RegAddr;
	logic [1:0] RegBe;
	data_t      RegWdata;
	data_t      RegRdata;
	data_t      PwmL;
	data_t      PwmR;
	logic       PwmIrq;
	logic       PwmDreq;

	bit randTick;
	bit tableReady;
	int errCount;
	int testsRun;
	int dreqCount;
	int rowCount;

	// Scaling table with one entry per row
	width_t rowCycle [nRows];
	width_t rowLeft  [nRows];
	width_t rowRight [nRows];
	bit     rowMono  [nRows];
	bit     rowRand  [nRows];
	int     rowWait  [nRows];   // Settle time in periods

	pwmUnit #(.FifoDepth(3)) DUT (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.Tick     (Tick),
		.RegWr    (RegWr),
		.RegAddr  (RegAddr),
		.RegBe    (RegBe),
		.RegWdata (RegWdata),
		.RegRd    (RegRd),
		.RegRdata (RegRdata),
		.PwmL     (PwmL),
		.PwmR     (PwmR),
		.PwmIrq   (PwmIrq),
		.PwmDreq  (PwmDreq)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Tick every cycle or at random
	initial begin
		void'($urandom(32'h84b6_3505));
		forever begin
			@(negedge CLK);
			Tick = randTick ? 1'($urandom % 2) : 1'b1;
		end
	end

	always @(negedge CLK) begin
		if (PwmDreq === 1'b1)
			dreqCount++;
	end

	// Expected sample as a signed offset from half the cycle
	function automatic data_t expSample(int pw, int cyc);
		int         v;
		logic [11:0] v12;
		if (pw == 0)
			v = 0;
		else if (pw > cyc)
			v = cyc / 2;
		else
			v = pw - cyc / 2;
		v12 = v[11:0];
		if (cyc < 2048)
			return (v12[11] ? 16'h8000 : 16'h0000) | (data_t'(v12 & 12'h3FF) << 5);
		return data_t'(v12) << 4;
	endfunction

	task automatic addRow(width_t cyc, width_t l, width_t r, bit mono, int waitP, bit rnd);
		rowCycle[rowCount] = cyc;
		rowLeft[rowCount]  = l;
		rowRight[rowCount] = r;
		rowMono[rowCount]  = mono;
		rowWait[rowCount]  = waitP;
		rowRand[rowCount]  = rnd;
		rowCount++;
	endtask

	task automatic writeReg(regOfs_t addr, data_t data, logic [1:0] be);
		@(negedge CLK);
		RegWr    = 1'b1;
		RegAddr  = addr;
		RegBe    = be;
		RegWdata = data;
		@(negedge CLK);
		RegWr = 1'b0;
	endtask

	task automatic readReg(regOfs_t addr, output data_t val);
		@(negedge CLK);
		RegRd   = 1'b1;
		RegAddr = addr;
		@(negedge CLK);
		RegRd = 1'b0;
		val   = RegRdata;
	endtask

	task automatic compareData(data_t got, data_t exp, string what);
		if (got !== exp) begin
			errCount++;
			$display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compareBit(logic got, logic exp, string what);
		if (got !== exp) begin
			errCount++;
			$display("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Polls the empty flags of both FIFOs
	task automatic waitFifos(bit wantEmpty, int limit, string what);
		data_t l;
		data_t r;
		int    spent;
		bit    done;
		spent = 0;
		done  = 1'b0;
		while (!done && spent < limit) begin
			readReg(RegLeft, l);
			readReg(RegRight, r);
			done  = l[14] == wantEmpty && r[14] == wantEmpty;
			spent += 4;
		end
		if (!done) begin
			errCount++;
			$display("Timed out after %0d cycles waiting for %s", limit, what);
		end
	endtask

	task automatic waitLeftChange(int limit);
		data_t old;
		int    n;
		old = PwmL;
		n   = 0;
		while (PwmL === old && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (PwmL === old) begin
			errCount++;
			$display("PwmL did not change within %0d cycles", limit);
		end
	endtask

	task automatic finishTest(string name, int errsBefore);
		testsRun++;
		if (errCount == errsBefore)
			$display("PASS %s", name);
		else
			$display("FAIL %s (%0d errors)", name, errCount - errsBefore);
	endtask

	task automatic runRow(int i);
		data_t expL;
		data_t expR;
		int    errs;
		int    limit;
		errs  = errCount;
		limit = rowWait[i] * rowCycle[i] * (rowRand[i] ? 4 : 1) + 64;
		writeReg(RegCtrl, 16'h0000, 2'b11);
		writeReg(RegCycle, data_t'(rowCycle[i]), 2'b11);
		randTick <= rowRand[i];
		if (rowMono[i]) begin
			writeReg(RegMono, data_t'(rowRight[i]), 2'b11);
			writeReg(RegLeft, data_t'(rowLeft[i]), 2'b11);   // Left-only entry that mono ignores
		end else begin
			writeReg(RegLeft, data_t'(rowLeft[i]), 2'b11);
			writeReg(RegRight, data_t'(rowRight[i]), 2'b11);
		end
		waitFifos(1'b0, 64, "width pushes");
		writeReg(RegCtrl, rowMono[i] ? 16'h0013 : 16'h0003, 2'b11);
		waitFifos(1'b1, limit, "FIFO drain");   // Scaler updates on the popping edge
		expR = expSample(rowRight[i], rowCycle[i]);
		expL = rowMono[i] ? expR : expSample(rowLeft[i], rowCycle[i]);
		compareData(PwmL, expL, $sformatf("row %0d PwmL", i));
		compareData(PwmR, expR, $sformatf("row %0d PwmR", i));
		randTick <= 1'b0;
		finishTest($sformatf("scaling row %0d", i), errs);
	endtask

	// Ends a stuck run with a budget from the table
	initial begin
		int limitNs;
		wait (tableReady);
		limitNs = 40000;
		for (int i = 0; i < nRows; i++)
			limitNs += rowWait[i] * rowCycle[i] * (rowRand[i] ? 4 : 1) * 4;
		#(limitNs);
		$display("Watchdog: run did not finish within %0d ns", limitNs);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		data_t rd;
		int    errs;
		int    dreqBase;
		RST_N    = 1'b0;
		Tick     = 1'b0;
		RegWr    = 1'b0;
		RegRd    = 1'b0;
		RegAddr  = RegCtrl;
		RegBe    = 2'b00;
		RegWdata = '0;
		addRow(12'd100, 12'd0, 12'd30, 1'b0, 2, 1'b0);
		addRow(12'd100, 12'd150, 12'd75, 1'b0, 2, 1'b0);   // Left above cycle
		addRow(12'h900, 12'h200, 12'h700, 1'b0, 2, 1'b0);
		addRow(12'd200, 12'd0, 12'd40, 1'b1, 2, 1'b0);
		addRow(12'd60, 12'd45, 12'd10, 1'b0, 2, 1'b1);
		tableReady = 1'b1;
		repeat (2) @(negedge CLK);
		RST_N = 1'b1;

		errs = errCount;
		readReg(RegCtrl, rd);
		compareData(rd, 16'h0000, "reset ctrl");
		readReg(RegCycle, rd);
		compareData(rd, 16'h0000, "reset cycle");
		readReg(RegLeft, rd);
		compareData(rd, 16'h4000, "reset left status");
		readReg(RegRight, rd);
		compareData(rd, 16'h4000, "reset right status");
		compareData(PwmL, 16'h0000, "reset PwmL");
		compareData(PwmR, 16'h0000, "reset PwmR");
		compareBit(PwmIrq, 1'b0, "reset PwmIrq");
		compareBit(PwmDreq, 1'b0, "reset PwmDreq");
		finishTest("reset state", errs);

		errs = errCount;
		writeReg(RegCycle, 16'hFFFF, 2'b11);
		readReg(RegCycle, rd);
		compareData(rd, 16'h0FFF, "cycle masked");
		writeReg(RegCycle, 16'h0000, 2'b10);
		readReg(RegCycle, rd);
		compareData(rd, 16'h00FF, "cycle high byte only");
		writeReg(RegCtrl, 16'hFFFF, 2'b11);
		readReg(RegCtrl, rd);
		compareData(rd, 16'h0F93, "ctrl masked");
		writeReg(RegCtrl, 16'h0000, 2'b01);
		readReg(RegCtrl, rd);
		compareData(rd, 16'h0F00, "ctrl low byte only");
		writeReg(RegCtrl, 16'h0000, 2'b11);
		writeReg(RegCycle, 16'h0000, 2'b11);
		finishTest("register masking", errs);

		// Three fit and the fourth is dropped
		errs = errCount;
		writeReg(RegCycle, 16'd16, 2'b11);
		writeReg(RegLeft, 16'd3, 2'b11);
		writeReg(RegLeft, 16'd6, 2'b11);
		writeReg(RegLeft, 16'd10, 2'b11);
		readReg(RegLeft, rd);
		compareData(rd, 16'h800A, "left full after three");
		writeReg(RegLeft, 16'd14, 2'b11);
		repeat (2) @(negedge CLK);
		readReg(RegLeft, rd);
		compareData(rd, 16'h800E, "left full after fourth");
		writeReg(RegCtrl, 16'h0001, 2'b11);
		waitLeftChange(64);
		compareData(PwmL, expSample(3, 16), "first sample");
		waitLeftChange(64);
		compareData(PwmL, expSample(6, 16), "second sample");
		waitLeftChange(64);
		compareData(PwmL, expSample(10, 16), "third sample");
		repeat (3 * 16 + 4) @(negedge CLK);
		compareData(PwmL, expSample(10, 16), "PwmL after drain");
		readReg(RegLeft, rd);
		compareData(rd, 16'h400E, "left empty after drain");
		finishTest("FIFO capacity", errs);

		for (int i = 0; i < nRows; i++)
			runRow(i);

		errs = errCount;
		writeReg(RegCtrl, 16'h0000, 2'b11);
		writeReg(RegCycle, 16'd8, 2'b11);
		writeReg(RegIrqClr, 16'h0000, 2'b11);
		compareBit(PwmIrq, 1'b0, "PwmIrq cleared before run");
		dreqBase = dreqCount;
		writeReg(RegCtrl, 16'h0281, 2'b11);   // Tm 2 with Rtp and left on
		for (int n = 0; n < 100 && PwmIrq !== 1'b1; n++)
			@(negedge CLK);
		compareBit(PwmIrq, 1'b1, "PwmIrq after periods");
		writeReg(RegIrqClr, 16'h0000, 2'b11);
		compareBit(PwmIrq, 1'b0, "PwmIrq after clear");
		repeat (4) @(negedge CLK);
		compareBit(dreqCount > dreqBase, 1'b1, "PwmDreq pulse seen");
		writeReg(RegCtrl, 16'h0201, 2'b11);
		repeat (2) @(negedge CLK);
		dreqBase = dreqCount;
		repeat (40) @(negedge CLK);
		compareBit(dreqCount == dreqBase, 1'b1, "no PwmDreq with Rtp clear");
		finishTest("timer interrupt and request", errs);

		$display("%0d tests run, %0d errors", testsRun, errCount);
		if (errCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
src/pwmPkg.sv
src/pwFifo.sv
src/pwmRegs.sv
src/pwmTimer.sv
src/pwmScaler.sv
src/pwmUnit.sv
tb/tbPwmUnit.sv
